/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_axi_xbar_wr -f src.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module tb_axi_xbar_wr -f src.f

clean:
	rm -rf obj_dir sim.log

/* design/aw_channel.sv */
`timescale 1ns/1ps

module aw_channel (
    input  logic                            clk,
    input  logic                            rst_n,
    input  axi_pkg::aw_chan_t               m_aw       [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0] m_awvalid,
    output logic [xbar_pkg::MASTER_NUM-1:0] m_awready,
    output axi_pkg::s_aw_chan_t             s_aw       [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::SLAVE_NUM-1:0]  s_awvalid,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]  s_awready,
    input  logic [xbar_pkg::MASTER_NUM-1:0] order_full,
    output logic [xbar_pkg::MASTER_NUM-1:0] aw_accept,
    output xbar_pkg::slave_sel_t            aw_sel     [xbar_pkg::MASTER_NUM]
);

    xbar_pkg::slave_sel_t  aw_req   [xbar_pkg::MASTER_NUM];
    xbar_pkg::slave_sel_t  aw_grant [xbar_pkg::MASTER_NUM];
    xbar_pkg::master_sel_t aw_rank  [xbar_pkg::MASTER_NUM];
    xbar_pkg::ext_id_u     ext_id   [xbar_pkg::MASTER_NUM];
    axi_pkg::s_aw_chan_t   aw_ext   [xbar_pkg::MASTER_NUM];

    always_comb begin
        for (int i = 0; i < xbar_pkg::MASTER_NUM; i++) begin
            aw_sel[i] = xbar_pkg::slave_sel_t'(1) << m_aw[i].addr[xbar_pkg::SLAVE_SEL_BIT];
            // full order FIFO parks the request
            aw_req[i]    = (m_awvalid[i] && !order_full[i]) ? aw_sel[i] : '0;
            m_awready[i] = |(aw_grant[i] & s_awready);
            aw_accept[i] = m_awvalid[i] & m_awready[i];

            ext_id[i].raw = {xbar_pkg::MASTER_IDX_W'(i), m_aw[i].id};
            aw_ext[i] = '{id: ext_id[i], addr: m_aw[i].addr, len: m_aw[i].len,
                          size: m_aw[i].size, burst: m_aw[i].burst, lock: m_aw[i].lock,
                          cache: m_aw[i].cache, prot: m_aw[i].prot};
        end
    end

    always_comb begin
        for (int j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin
            s_awvalid[j] = 1'b0;
            s_aw[j]      = '0;
            for (int i = 0; i < xbar_pkg::MASTER_NUM; i++) begin
                if (aw_grant[i][j]) begin
                    s_awvalid[j] = 1'b1;
                    s_aw[j]      = aw_ext[i];
                end
            end
        end
    end

    rr_priority #(
        .SENDER_NUM(xbar_pkg::MASTER_NUM)
    ) u_aw_prio (
        .clk  (clk),
        .rst_n(rst_n),
        .hs   (aw_accept),
        .rank (aw_rank)
    );

    grant_matrix #(
        .SENDER_NUM  (xbar_pkg::MASTER_NUM),
        .RECEIVER_NUM(xbar_pkg::SLAVE_NUM)
    ) u_aw_grant (
        .req  (aw_req),
        .rank (aw_rank),
        .grant(aw_grant)
    );

endmodule

/* design/axi_pkg.sv */
package axi_pkg;

    localparam int ID_W   = $bits(xbar_pkg::ext_id_fields_t) - xbar_pkg::MASTER_IDX_W;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [1:0]        lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } aw_chan_t;

    // slave side carries the widened id
    typedef struct packed {
        xbar_pkg::ext_id_u id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [1:0]        lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
    } s_aw_chan_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_chan_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } b_chan_t;

    typedef struct packed {
        xbar_pkg::ext_id_u id;
        logic [1:0]        resp;
    } s_b_chan_t;

endpackage

/* design/axi_xbar_wr.sv */
`timescale 1ns/1ps

module axi_xbar_wr (
    input  logic                            clk,
    input  logic                            rst_n,

    input  axi_pkg::aw_chan_t               m_aw       [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0] m_awvalid,
    output logic [xbar_pkg::MASTER_NUM-1:0] m_awready,
    input  axi_pkg::w_chan_t                m_w        [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0] m_wvalid,
    output logic [xbar_pkg::MASTER_NUM-1:0] m_wready,
    output axi_pkg::b_chan_t                m_b        [xbar_pkg::MASTER_NUM],
    output logic [xbar_pkg::MASTER_NUM-1:0] m_bvalid,
    input  logic [xbar_pkg::MASTER_NUM-1:0] m_bready,

    output axi_pkg::s_aw_chan_t             s_aw       [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::SLAVE_NUM-1:0]  s_awvalid,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]  s_awready,
    output axi_pkg::w_chan_t                s_w        [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::SLAVE_NUM-1:0]  s_wvalid,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]  s_wready,
    input  axi_pkg::s_b_chan_t              s_b        [xbar_pkg::SLAVE_NUM],
    input  logic [xbar_pkg::SLAVE_NUM-1:0]  s_bvalid,
    output logic [xbar_pkg::SLAVE_NUM-1:0]  s_bready
);

    logic [xbar_pkg::MASTER_NUM-1:0] order_full;
    logic [xbar_pkg::MASTER_NUM-1:0] aw_accept;
    xbar_pkg::slave_sel_t            aw_sel [xbar_pkg::MASTER_NUM];

    aw_channel u_aw (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_aw      (m_aw),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .s_aw      (s_aw),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .order_full(order_full),
        .aw_accept (aw_accept),
        .aw_sel    (aw_sel)
    );

    w_channel u_w (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_accept (aw_accept),
        .aw_sel    (aw_sel),
        .order_full(order_full),
        .m_w       (m_w),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .s_w       (s_w),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready)
    );

    b_channel u_b (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_b     (s_b),
        .s_bvalid(s_bvalid),
        .s_bready(s_bready),
        .m_b     (m_b),
        .m_bvalid(m_bvalid),
        .m_bready(m_bready)
    );

endmodule

/* design/b_channel.sv */
`timescale 1ns/1ps

module b_channel (
    input  logic                            clk,
    input  logic                            rst_n,
    input  axi_pkg::s_b_chan_t              s_b       [xbar_pkg::SLAVE_NUM],
    input  logic [xbar_pkg::SLAVE_NUM-1:0]  s_bvalid,
    output logic [xbar_pkg::SLAVE_NUM-1:0]  s_bready,
    output axi_pkg::b_chan_t                m_b       [xbar_pkg::MASTER_NUM],
    output logic [xbar_pkg::MASTER_NUM-1:0] m_bvalid,
    input  logic [xbar_pkg::MASTER_NUM-1:0] m_bready
);

    xbar_pkg::master_sel_t          b_req   [xbar_pkg::SLAVE_NUM];
    xbar_pkg::master_sel_t          b_grant [xbar_pkg::SLAVE_NUM];
    xbar_pkg::slave_sel_t           b_rank  [xbar_pkg::SLAVE_NUM];
    logic [xbar_pkg::SLAVE_NUM-1:0] b_hs;

    always_comb begin
        for (int j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin
            // prefix names the master that issued the AW
            b_req[j]    = s_bvalid[j] ?
                          xbar_pkg::master_sel_t'(1) << s_b[j].id.fields.master_idx : '0;
            s_bready[j] = |(b_grant[j] & m_bready);
            b_hs[j]     = s_bvalid[j] & s_bready[j];
        end
    end

    always_comb begin
        for (int i = 0; i < xbar_pkg::MASTER_NUM; i++) begin
            m_bvalid[i] = 1'b0;
            m_b[i]      = '0;
            for (int j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin
                if (b_grant[j][i]) begin
                    m_bvalid[i] = 1'b1;
                    m_b[i]      = '{id: s_b[j].id.fields.id, resp: s_b[j].resp};
                end
            end
        end
    end

    rr_priority #(
        .SENDER_NUM(xbar_pkg::SLAVE_NUM)
    ) u_b_prio (
        .clk  (clk),
        .rst_n(rst_n),
        .hs   (b_hs),
        .rank (b_rank)
    );

    grant_matrix #(
        .SENDER_NUM  (xbar_pkg::SLAVE_NUM),
        .RECEIVER_NUM(xbar_pkg::MASTER_NUM)
    ) u_b_grant (
        .req  (b_req),
        .rank (b_rank),
        .grant(b_grant)
    );

    for (genvar j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin : g_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            s_bvalid[j] |-> int'(s_b[j].id.fields.master_idx) < xbar_pkg::MASTER_NUM)
            else $error("slave %0d returned a response for an unknown master", j);
    end

endmodule

/* design/grant_matrix.sv */
`timescale 1ns/1ps

module grant_matrix #(
    parameter int SENDER_NUM   = 2,
    parameter int RECEIVER_NUM = 2
) (
    input  logic [RECEIVER_NUM-1:0] req   [SENDER_NUM],
    input  logic [SENDER_NUM-1:0]   rank  [SENDER_NUM],
    output logic [RECEIVER_NUM-1:0] grant [SENDER_NUM]
);

    always_comb begin
        for (int i = 0; i < SENDER_NUM; i++) begin
            for (int r = 0; r < RECEIVER_NUM; r++) begin
                grant[i][r] = req[i][r];
                // any higher ranked rival for the same receiver blocks it
                for (int k = 0; k < SENDER_NUM; k++) begin
                    if (k != i && req[k][r] && !rank[i][k]) begin
                        grant[i][r] = 1'b0;
                    end
                end
            end
        end
    end

    always_comb begin
        logic [SENDER_NUM-1:0] taken;
        for (int r = 0; r < RECEIVER_NUM; r++) begin
            for (int i = 0; i < SENDER_NUM; i++) begin
                taken[i] = grant[i][r];
            end
            assert ($onehot0(taken)) else $error("receiver %0d granted to two senders", r);
        end
        for (int i = 0; i < SENDER_NUM; i++) begin
            assert ($onehot0(grant[i])) else $error("sender %0d granted two receivers", i);
        end
    end

endmodule

/* design/rr_priority.sv */
`timescale 1ns/1ps

// rank[i][k] set means sender i wins over sender k
module rr_priority #(
    parameter int SENDER_NUM = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [SENDER_NUM-1:0] hs,
    output logic [SENDER_NUM-1:0] rank [SENDER_NUM]
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // lower index first out of reset
            for (int i = 0; i < SENDER_NUM; i++) begin
                for (int k = 0; k < SENDER_NUM; k++) begin
                    rank[i][k] <= (i < k);
                end
            end
        end else begin
            // winners drop below the rest with the order inside each group kept
            for (int i = 0; i < SENDER_NUM; i++) begin
                for (int k = 0; k < SENDER_NUM; k++) begin
                    if (hs[i] && !hs[k]) begin
                        rank[i][k] <= 1'b0;
                    end else if (hs[k] && !hs[i]) begin
                        rank[i][k] <= 1'b1;
                    end
                end
            end
        end
    end

    for (genvar i = 0; i < SENDER_NUM; i++) begin : g_chk
        for (genvar k = i + 1; k < SENDER_NUM; k++) begin : g_pair
            assert property (@(posedge clk) disable iff (!rst_n) rank[i][k] != rank[k][i])
                else $error("rank order broken between senders %0d and %0d", i, k);
        end
    end

endmodule

/* design/w_channel.sv */
`timescale 1ns/1ps

module w_channel (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [xbar_pkg::MASTER_NUM-1:0] aw_accept,
    input  xbar_pkg::slave_sel_t            aw_sel     [xbar_pkg::MASTER_NUM],
    output logic [xbar_pkg::MASTER_NUM-1:0] order_full,
    input  axi_pkg::w_chan_t                m_w        [xbar_pkg::MASTER_NUM],
    input  logic [xbar_pkg::MASTER_NUM-1:0] m_wvalid,
    output logic [xbar_pkg::MASTER_NUM-1:0] m_wready,
    output axi_pkg::w_chan_t                s_w        [xbar_pkg::SLAVE_NUM],
    output logic [xbar_pkg::SLAVE_NUM-1:0]  s_wvalid,
    input  logic [xbar_pkg::SLAVE_NUM-1:0]  s_wready
);

    xbar_pkg::slave_sel_t            head_sel [xbar_pkg::MASTER_NUM];
    logic [xbar_pkg::MASTER_NUM-1:0] order_empty;
    logic [xbar_pkg::MASTER_NUM-1:0] last_hs;
    xbar_pkg::slave_sel_t            w_req    [xbar_pkg::MASTER_NUM];
    xbar_pkg::slave_sel_t            w_grant  [xbar_pkg::MASTER_NUM];
    xbar_pkg::master_sel_t           w_rank   [xbar_pkg::MASTER_NUM];
    xbar_pkg::master_sel_t           w_col    [xbar_pkg::SLAVE_NUM];
    // owner of a burst that has started at each slave
    xbar_pkg::master_sel_t           w_lock   [xbar_pkg::SLAVE_NUM];

    for (genvar i = 0; i < xbar_pkg::MASTER_NUM; i++) begin : g_order
        wr_order_fifo u_order (
            .clk     (clk),
            .rst_n   (rst_n),
            .push    (aw_accept[i]),
            .push_sel(aw_sel[i]),
            .pop     (last_hs[i]),
            .head_sel(head_sel[i]),
            .empty   (order_empty[i]),
            .full    (order_full[i])
        );
    end

    always_comb begin
        for (int i = 0; i < xbar_pkg::MASTER_NUM; i++) begin
            for (int j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin
                w_req[i][j] = !order_empty[i] && head_sel[i][j] &&
                              (w_lock[j] == '0 || w_lock[j][i]);
            end
            m_wready[i] = |(w_grant[i] & s_wready);
            last_hs[i]  = m_wvalid[i] & m_wready[i] & m_w[i].last;
        end
    end

    always_comb begin
        for (int j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin
            s_wvalid[j] = 1'b0;
            s_w[j]      = '0;
            for (int i = 0; i < xbar_pkg::MASTER_NUM; i++) begin
                w_col[j][i] = w_grant[i][j];
                if (w_grant[i][j]) begin
                    s_wvalid[j] = m_wvalid[i];
                    s_w[j]      = m_w[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin
                w_lock[j] <= '0;
            end
        end else begin
            for (int j = 0; j < xbar_pkg::SLAVE_NUM; j++) begin
                if (s_wvalid[j] && s_wready[j]) begin
                    w_lock[j] <= s_w[j].last ? '0 : w_col[j];
                end
            end
        end
    end

    // ranks move on burst ends only
    rr_priority #(
        .SENDER_NUM(xbar_pkg::MASTER_NUM)
    ) u_w_prio (
        .clk  (clk),
        .rst_n(rst_n),
        .hs   (last_hs),
        .rank (w_rank)
    );

    grant_matrix #(
        .SENDER_NUM  (xbar_pkg::MASTER_NUM),
        .RECEIVER_NUM(xbar_pkg::SLAVE_NUM)
    ) u_w_grant (
        .req  (w_req),
        .rank (w_rank),
        .grant(w_grant)
    );

endmodule

/* design/wr_order_fifo.sv */
`timescale 1ns/1ps

module wr_order_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  xbar_pkg::slave_sel_t push_sel,
    input  logic                 pop,
    output xbar_pkg::slave_sel_t head_sel,
    output logic                 empty,
    output logic                 full
);

    xbar_pkg::slave_sel_t              mem [xbar_pkg::W_ORDER_DEPTH];
    logic [xbar_pkg::W_ORDER_PTR_W-1:0] wr_ptr;
    logic [xbar_pkg::W_ORDER_PTR_W-1:0] rd_ptr;
    logic [xbar_pkg::W_ORDER_PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_sel;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_sel = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == (xbar_pkg::W_ORDER_PTR_W + 1)'(xbar_pkg::W_ORDER_DEPTH));

    // AW side holds off on full and W side only ends bursts it owns
    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("write order FIFO pushed while full");
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("write order FIFO popped while empty");

endmodule

/* design/xbar_pkg.sv */
package xbar_pkg;

    localparam int MASTER_NUM    = 2;
    localparam int MASTER_IDX_W  = 1;
    localparam int SLAVE_NUM     = 2;
    // bursts in flight per master
    localparam int W_ORDER_DEPTH = 4;
    localparam int W_ORDER_PTR_W = $clog2(W_ORDER_DEPTH);
    // slave 0 owns the lower half of the map
    localparam int SLAVE_SEL_BIT = 31;

    typedef logic [SLAVE_NUM-1:0]  slave_sel_t;
    typedef logic [MASTER_NUM-1:0] master_sel_t;

    // master-side id is the low 4 bits
    typedef struct packed {
        logic [MASTER_IDX_W-1:0] master_idx;
        logic [3:0]              id;
    } ext_id_fields_t;

    typedef union packed {
        logic [$bits(ext_id_fields_t)-1:0] raw;
        ext_id_fields_t                    fields;
    } ext_id_u;

endpackage

/* src.f */
design/xbar_pkg.sv
design/axi_pkg.sv
design/rr_priority.sv
design/grant_matrix.sv
design/wr_order_fifo.sv
design/aw_channel.sv
design/w_channel.sv
design/b_channel.sv
design/axi_xbar_wr.sv
tb/xbar_checker.sv
tb/tb_axi_xbar_wr.sv

/* tb/tb_axi_xbar_wr.sv */
`timescale 1ns/1ps

module tb_axi_xbar_wr;

    localparam int LIMIT = 200;

    logic                clk;
    logic                rst_n;
    axi_pkg::aw_chan_t   m_aw [2];
    logic [1:0]          m_awvalid;
    logic [1:0]          m_awready;
    axi_pkg::w_chan_t    m_w [2];
    logic [1:0]          m_wvalid;
    logic [1:0]          m_wready;
    axi_pkg::b_chan_t    m_b [2];
    logic [1:0]          m_bvalid;
    logic [1:0]          m_bready;
    axi_pkg::s_aw_chan_t s_aw [2];
    logic [1:0]          s_awvalid;
    logic [1:0]          s_awready;
    axi_pkg::w_chan_t    s_w [2];
    logic [1:0]          s_wvalid;
    logic [1:0]          s_wready;
    axi_pkg::s_b_chan_t  s_b [2];
    logic [1:0]          s_bvalid;
    logic [1:0]          s_bready;

    logic        awvalid_d [2];
    logic        wvalid_d  [2];
    logic [31:0] rng = 32'hc00b;
    bit          force_ready = 1'b0;
    bit          hung = 1'b0;
    int          stim_errors = 0;
    int          tags = 0;
    // extended ids of accepted AWs and pending {ext id, resp} per slave
    logic [4:0]  aw_q [2][$];
    logic [6:0]  b_q  [2][$];

    assign m_awvalid = {awvalid_d[1], awvalid_d[0]};
    assign m_wvalid  = {wvalid_d[1], wvalid_d[0]};

    axi_xbar_wr uut (.*);

    xbar_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic wait_ready(input int m, input bit is_aw, output bit ok);
        ok = 1'b0;
        for (int t = 0; t < LIMIT && !ok; t++) begin
            @(posedge clk);
            ok = is_aw ? m_awready[m] : m_wready[m];
        end
        if (!ok) begin
            $display("master %0d waited too long for %s ready", m, is_aw ? "AW" : "W");
            hung = 1'b1;
        end
    endtask

    task automatic drive_aw(input int m, input bit low_half, input logic [7:0] len);
        logic [31:0] r;
        logic [31:0] addr;
        r    = next_rand();
        addr = next_rand();
        if (low_half) addr[31] = 1'b0;
        @(negedge clk);
        m_aw[m] = '{id: r[3:0], addr: addr, len: len, size: 3'd2, burst: 2'b01,
                    lock: 2'b00, cache: 4'h0, prot: 3'h0};
        awvalid_d[m] = 1'b1;
    endtask

    // starts and ends at a falling edge
    task automatic send_burst(input int m, input logic [7:0] len, output bit ok);
        ok = 1'b1;
        tags++;
        for (int b = 0; b <= int'(len) && ok; b++) begin
            m_w[m] = '{data: {m[3:0], tags[19:0], b[7:0]}, strb: 4'hf, last: b == int'(len)};
            wvalid_d[m] = 1'b1;
            wait_ready(m, 1'b0, ok);
            @(negedge clk);
            wvalid_d[m] = 1'b0;
        end
    endtask

    task automatic run_master(input int m, input int bursts, input bit low_half);
        bit          ok;
        logic [31:0] r;
        ok = 1'b1;
        for (int n = 0; n < bursts && ok; n++) begin
            r = next_rand();
            drive_aw(m, low_half, {6'd0, r[1:0]});
            wait_ready(m, 1'b1, ok);
            @(negedge clk);
            awvalid_d[m] = 1'b0;
            if (ok) send_burst(m, {6'd0, r[1:0]}, ok);
        end
    endtask

    // four open bursts must stall a fifth AW
    task automatic fill_order();
        bit ok;
        ok = 1'b1;
        for (int n = 0; n < 4 && ok; n++) begin
            drive_aw(0, 1'b1, 8'd0);
            wait_ready(0, 1'b1, ok);
            @(negedge clk);
            awvalid_d[0] = 1'b0;
        end
        drive_aw(0, 1'b1, 8'd0);
        repeat (6) begin
            @(posedge clk);
            if (m_awready[0]) begin
                stim_errors++;
                $display("Error %0t: awready high with four bursts open", $time);
            end
        end
        @(negedge clk);
        if (ok) send_burst(0, 8'd0, ok);
        if (ok) wait_ready(0, 1'b1, ok);
        @(negedge clk);
        awvalid_d[0] = 1'b0;
        for (int n = 0; n < 4 && ok; n++) send_burst(0, 8'd0, ok);
    endtask

    // slave models
    initial begin
        logic [31:0] r;
        int          idx;
        s_awready = '0;
        s_wready  = '0;
        s_bvalid  = '0;
        s_b       = '{default: '0};
        m_bready  = '0;
        forever begin
            @(posedge clk);
            r = next_rand();
            for (int j = 0; j < 2; j++) begin
                if (s_awvalid[j] && s_awready[j]) aw_q[j].push_back(s_aw[j].id.raw);
                if (s_wvalid[j] && s_wready[j] && s_w[j].last) begin
                    idx = -1;
                    for (int k = aw_q[j].size() - 1; k >= 0; k--) begin
                        if (aw_q[j][k][4] == s_w[j].data[28]) idx = k;
                    end
                    if (idx < 0) begin
                        stim_errors++;
                        $display("Error %0t: slave %0d got a burst with no AW", $time, j);
                    end else begin
                        b_q[j].push_back({aw_q[j][idx], r[2*j+1 -: 2]});
                        aw_q[j].delete(idx);
                    end
                end
                if (s_bvalid[j] && s_bready[j]) void'(b_q[j].pop_front());
            end
            @(negedge clk);
            r = next_rand();
            s_awready = force_ready ? 2'b11 : (r[1:0] | r[3:2]);
            s_wready  = r[5:4] | r[7:6];
            m_bready  = r[9:8] | r[11:10];
            for (int j = 0; j < 2; j++) begin
                s_bvalid[j] = b_q[j].size() != 0;
                s_b[j]      = b_q[j].size() != 0 ? b_q[j][0] : 7'd0;
            end
        end
    end

    initial begin
        bit drained;
        rst_n     = 1'b0;
        awvalid_d = '{1'b0, 1'b0};
        wvalid_d  = '{1'b0, 1'b0};
        m_aw      = '{default: '0};
        m_w       = '{default: '0};
        drained   = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        fork
            run_master(0, 40, 1'b0);
            run_master(1, 40, 1'b0);
        join
        force_ready = 1'b1;
        if (!hung) begin
            fork
                run_master(0, 8, 1'b1);
                run_master(1, 8, 1'b1);
            join
        end
        if (!hung) fill_order();
        force_ready = 1'b0;

        for (int t = 0; t < LIMIT && !drained; t++) begin
            @(posedge clk);
            drained = b_q[0].size() == 0 && b_q[1].size() == 0 &&
                      aw_q[0].size() == 0 && aw_q[1].size() == 0;
        end
        if (!drained) $display("responses still pending when the drain wait ran out");

        $display("cycles checked %0d, checker errors %0d, testbench errors %0d",
                 chk.checks, chk.errors, stim_errors);
        if (hung || !drained || chk.errors != 0 || stim_errors != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    end

endmodule

/* tb/xbar_checker.sv */
`timescale 1ns/1ps

module xbar_checker (
    input logic                            clk,
    input logic                            rst_n,
    input axi_pkg::aw_chan_t               m_aw      [xbar_pkg::MASTER_NUM],
    input logic [xbar_pkg::MASTER_NUM-1:0] m_awvalid,
    input logic [xbar_pkg::MASTER_NUM-1:0] m_awready,
    input axi_pkg::w_chan_t                m_w       [xbar_pkg::MASTER_NUM],
    input logic [xbar_pkg::MASTER_NUM-1:0] m_wvalid,
    input logic [xbar_pkg::MASTER_NUM-1:0] m_wready,
    input axi_pkg::b_chan_t                m_b       [xbar_pkg::MASTER_NUM],
    input logic [xbar_pkg::MASTER_NUM-1:0] m_bvalid,
    input logic [xbar_pkg::MASTER_NUM-1:0] m_bready,
    input axi_pkg::s_aw_chan_t             s_aw      [xbar_pkg::SLAVE_NUM],
    input logic [xbar_pkg::SLAVE_NUM-1:0]  s_awvalid,
    input logic [xbar_pkg::SLAVE_NUM-1:0]  s_awready,
    input axi_pkg::w_chan_t                s_w       [xbar_pkg::SLAVE_NUM],
    input logic [xbar_pkg::SLAVE_NUM-1:0]  s_wvalid,
    input logic [xbar_pkg::SLAVE_NUM-1:0]  s_wready,
    input axi_pkg::s_b_chan_t              s_b       [xbar_pkg::SLAVE_NUM],
    input logic [xbar_pkg::SLAVE_NUM-1:0]  s_bvalid,
    input logic [xbar_pkg::SLAVE_NUM-1:0]  s_bready
);

    int errors = 0;
    int checks = 0;
    // open bursts per master with the oldest first
    int aw_slave [2][$];
    int aw_len   [2][$];
    int beat     [2] = '{0, 0};
    int owner    [2] = '{-1, -1};
    // master with AW priority
    int prio = 0;
    bit started = 1'b0;

    function automatic int expected_slave(input logic [31:0] addr);
        return addr[31] ? 1 : 0;
    endfunction

    function automatic logic [4:0] expected_ext_id(input int m, input logic [3:0] id);
        return {m[0], id};
    endfunction

    // same payload with the widened id
    function automatic axi_pkg::s_aw_chan_t expected_s_aw(input int m,
                                                          input axi_pkg::aw_chan_t aw);
        axi_pkg::s_aw_chan_t s;
        s.id.raw = expected_ext_id(m, aw.id);
        s.addr   = aw.addr;
        s.len    = aw.len;
        s.size   = aw.size;
        s.burst  = aw.burst;
        s.lock   = aw.lock;
        s.cache  = aw.cache;
        s.prot   = aw.prot;
        return s;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("Error %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        int j;
        int m;
        if (rst_n) begin
            checks++;
            started = started | (|m_awvalid);
            if (!started && (s_awvalid != 0 || s_wvalid != 0 || m_wready != 0 || m_bvalid != 0))
                flag_error("DUT outputs active before any request");

            j = expected_slave(m_aw[0].addr);
            if (&m_awvalid && j == expected_slave(m_aw[1].addr) && s_awready[j] &&
                aw_slave[0].size() < 4 && aw_slave[1].size() < 4 &&
                !(m_awready[prio] && !m_awready[1-prio]))
                flag_error($sformatf("AW arbitration should pick master %0d", prio));

            if ($countones(s_awvalid & s_awready) != $countones(m_awvalid & m_awready))
                flag_error("AW handshake counts differ between sides");
            if ($countones(s_wvalid & s_wready) != $countones(m_wvalid & m_wready))
                flag_error("W handshake counts differ between sides");
            if ($countones(s_bvalid & s_bready) != $countones(m_bvalid & m_bready))
                flag_error("B handshake counts differ between sides");

            for (int i = 0; i < 2; i++) begin
                if (m_wvalid[i] && m_wready[i]) begin
                    j = aw_slave[i].size() ? aw_slave[i][0] : 0;
                    if (aw_slave[i].size() == 0 || !(s_wvalid[j] && s_wready[j]) ||
                        s_w[j] != m_w[i]) begin
                        flag_error($sformatf("W beat from master %0d misrouted", i));
                    end else begin
                        if (owner[j] != -1 && owner[j] != i)
                            flag_error($sformatf("bursts interleaved at slave %0d", j));
                        if (s_w[j].data[7:0] != beat[i][7:0] ||
                            s_w[j].last != (beat[i] == aw_len[i][0]))
                            flag_error($sformatf("W beat order broken for master %0d", i));
                        if (s_w[j].last) begin
                            void'(aw_slave[i].pop_front());
                            void'(aw_len[i].pop_front());
                            beat[i]  = 0;
                            owner[j] = -1;
                        end else begin
                            beat[i]++;
                            owner[j] = i;
                        end
                    end
                end
                if (m_awvalid[i] && m_awready[i]) begin
                    j = expected_slave(m_aw[i].addr);
                    if (aw_slave[i].size() == 4)
                        flag_error("AW accepted with a full order FIFO");
                    if (!(s_awvalid[j] && s_awready[j]) ||
                        s_aw[j] != expected_s_aw(i, m_aw[i]))
                        flag_error($sformatf("AW from master %0d misrouted", i));
                    aw_slave[i].push_back(j);
                    aw_len[i].push_back(int'(m_aw[i].len));
                end
            end

            for (int s = 0; s < 2; s++) begin
                if (s_bvalid[s] && s_bready[s]) begin
                    m = int'(s_b[s].id.raw[4]);
                    if (!(m_bvalid[m] && m_bready[m]) || m_b[m].id != s_b[s].id.raw[3:0] ||
                        m_b[m].resp != s_b[s].resp)
                        flag_error($sformatf("B from slave %0d misrouted", s));
                end
            end

            // the other master takes priority after a lone winner
            if (m_awvalid[0] && m_awready[0] && !(m_awvalid[1] && m_awready[1]))
                prio = 1;
            else if (m_awvalid[1] && m_awready[1] && !(m_awvalid[0] && m_awready[0]))
                prio = 0;
        end
    end

endmodule
